// File: src/stxPkg.sv
package stxPkg;

  // virtual address width
  localparam int ADDR_WIDTH = 32;

  // byte offset within a 32-bit data word
  localparam int BYTE_OFFSET_WIDTH = 2;

  // word part of the address, what is left above the byte offset
  localparam int WORD_ADDR_WIDTH = ADDR_WIDTH - BYTE_OFFSET_WIDTH;

  // physical register tag
  localparam int PHY_TAG_WIDTH = 7;

  // active-list index
  localparam int AL_ID_WIDTH = 7;

  // access size, encoded so a larger access compares greater
  typedef enum logic [1:0] {
    SIZE_BYTE,
    SIZE_HALF,
    SIZE_WORD
  } ldstSize_e;

  // word address and byte offset, as the overlap check splits it
  typedef struct packed {
    logic [WORD_ADDR_WIDTH-1:0]   wordAddr;
    logic [BYTE_OFFSET_WIDTH-1:0] byteOff;
  } memAddrParts_t;

  // one address word, seen flat or split
  typedef union packed {
    logic [ADDR_WIDTH-1:0] flat;
    memAddrParts_t         parts;
  } memAddr_u;

endpackage

// File: src/ldqView_if.sv
`timescale 1ns/1ps

interface ldqView_if #(
  parameter int lsqDepth = 8
);

  // load has its address, i.e. it has executed
  logic [lsqDepth-1:0] addrValid;

  // load has its data and has written back
  logic [lsqDepth-1:0] writeBack;

  // per-slot payload
  logic [stxPkg::AL_ID_WIDTH-1:0]   alId    [lsqDepth];
  logic [stxPkg::PHY_TAG_WIDTH-1:0] phyDest [lsqDepth];
  stxPkg::ldstSize_e                size    [lsqDepth];
  stxPkg::memAddr_u                 addr    [lsqDepth];

  // the payload storage drives everything
  modport owner (
    output addrValid, writeBack, alId, phyDest, size, addr
  );

  // checker and replay only look
  modport reader (
    input addrValid, writeBack, alId, phyDest, size, addr
  );

endinterface

// File: src/loadQueuePayload.sv
`timescale 1ns/1ps

module loadQueuePayload #(
  parameter int lsqDepth      = 8,
  parameter int dispatchWidth = 2,
  parameter int commitWidth   = 2
) (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              recover_i,
  input  logic                              backEndReady_i,
  input  logic                              ldValid_i,
  input  logic [$clog2(lsqDepth)-1:0]       ldLsqId_i,
  input  logic [stxPkg::PHY_TAG_WIDTH-1:0]  ldPhyDest_i,
  input  logic [stxPkg::AL_ID_WIDTH-1:0]    ldAlId_i,
  input  stxPkg::ldstSize_e                 ldSize_i,
  input  logic [stxPkg::ADDR_WIDTH-1:0]     ldAddr_i,
  input  logic                              loadDataValid_i,
  input  logic [dispatchWidth-1:0]          dispIsLoad_i,
  input  logic [$clog2(lsqDepth)-1:0]       dispLdqId_i [dispatchWidth],
  input  logic [$clog2(commitWidth):0]      commitLdCount_i,
  input  logic [$clog2(lsqDepth)-1:0]       commitLdIndex_i [commitWidth],
  ldqView_if.owner                          view
);

  // valid and written-back bits per slot
  logic [lsqDepth-1:0] addrValidQ;
  logic [lsqDepth-1:0] writeBackQ;

  // payload arrays
  logic [stxPkg::AL_ID_WIDTH-1:0]   alIdQ    [lsqDepth];
  logic [stxPkg::PHY_TAG_WIDTH-1:0] phyDestQ [lsqDepth];
  stxPkg::ldstSize_e                sizeQ    [lsqDepth];
  stxPkg::memAddr_u                 addrQ    [lsqDepth];

  // status bits
  // later statements win, so dispatch and commit clears override
  // an execute write to the same slot
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      addrValidQ <= '0;
      writeBackQ <= '0;
    end
    else if (recover_i)
    begin
      addrValidQ <= '0;
      writeBackQ <= '0;
    end
    else
    begin
      // new load or replayed load
      if (ldValid_i)
      begin
        addrValidQ[ldLsqId_i] <= 1'b1;
        writeBackQ[ldLsqId_i] <= loadDataValid_i;
      end
      if (backEndReady_i)
      begin
        // slot reused by a new load
        for (int d = 0; d < dispatchWidth; d++)
        begin
          if (dispIsLoad_i[d])
          begin
            addrValidQ[dispLdqId_i[d]] <= 1'b0;
            writeBackQ[dispLdqId_i[d]] <= 1'b0;
          end
        end
        // retiring loads, first commitLdCount_i lanes only
        for (int c = 0; c < commitWidth; c++)
        begin
          if (c < commitLdCount_i)
          begin
            addrValidQ[commitLdIndex_i[c]] <= 1'b0;
            writeBackQ[commitLdIndex_i[c]] <= 1'b0;
          end
        end
      end
    end
  end

  // payload, written on execute, wiped on recovery
  always_ff @(posedge clk)
  begin
    if (recover_i)
    begin
      for (int i = 0; i < lsqDepth; i++)
      begin
        alIdQ[i]    <= '0;
        phyDestQ[i] <= '0;
        sizeQ[i]    <= stxPkg::SIZE_BYTE;
        addrQ[i]    <= '0;
      end
    end
    else if (ldValid_i)
    begin
      alIdQ[ldLsqId_i]     <= ldAlId_i;
      phyDestQ[ldLsqId_i]  <= ldPhyDest_i;
      sizeQ[ldLsqId_i]     <= ldSize_i;
      addrQ[ldLsqId_i]     <= ldAddr_i;
    end
  end

  // registered state out to the readers
  assign view.addrValid = addrValidQ;
  assign view.writeBack = writeBackQ;
  assign view.alId      = alIdQ;
  assign view.phyDest   = phyDestQ;
  assign view.size      = sizeQ;
  assign view.addr      = addrQ;

endmodule

// File: src/followingLoadTable.sv
`timescale 1ns/1ps

module followingLoadTable #(
  parameter int lsqDepth      = 8,
  parameter int dispatchWidth = 2
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        recover_i,
  input  logic                        backEndReady_i,
  input  logic [dispatchWidth-1:0]    dispIsStore_i,
  input  logic [$clog2(lsqDepth)-1:0] dispStqId_i [dispatchWidth],
  input  logic [$clog2(lsqDepth)-1:0] dispNextLd_i [dispatchWidth],
  input  logic [$clog2(lsqDepth)-1:0] stLsqId_i,
  output logic [$clog2(lsqDepth)-1:0] nextLoad_o
);

  // first younger load, indexed by store slot
  logic [$clog2(lsqDepth)-1:0] nextLdTable [lsqDepth];

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < lsqDepth; i++)
        nextLdTable[i] <= '0;
    end
    else if (recover_i)
    begin
      for (int i = 0; i < lsqDepth; i++)
        nextLdTable[i] <= '0;
    end
    else if (backEndReady_i)
    begin
      // recorded as each store is dispatched
      for (int d = 0; d < dispatchWidth; d++)
      begin
        if (dispIsStore_i[d])
          nextLdTable[dispStqId_i[d]] <= dispNextLd_i[d];
      end
    end
  end

  // lookup for the executing store
  assign nextLoad_o = nextLdTable[stLsqId_i];

endmodule

// File: src/loadAgeWindow.sv
`timescale 1ns/1ps

module loadAgeWindow #(
  parameter int lsqDepth = 8
) (
  input  logic [$clog2(lsqDepth)-1:0] nextLoad_i,
  input  logic [$clog2(lsqDepth)-1:0] ldqHead_i,
  input  logic [$clog2(lsqDepth)-1:0] ldqTail_i,
  input  logic [$clog2(lsqDepth):0]   ldqCount_i,
  output logic [lsqDepth-1:0]         windowMask_o
);

  // range runs past the last slot back to zero
  logic ldqWrap;

  // every load in the queue is younger than the store
  logic ldqAllYounger;

  // straight and wrapped forms of the window
  logic [lsqDepth-1:0] straightMask;
  logic [lsqDepth-1:0] wrapMask;

  assign ldqWrap       = (ldqTail_i < nextLoad_i);
  assign ldqAllYounger = (ldqTail_i == nextLoad_i) && (ldqHead_i == nextLoad_i) &&
                         (ldqCount_i != '0);

  always_comb
  begin
    for (int i = 0; i < lsqDepth; i++)
    begin
      // nextLoad up to the tail, tail itself excluded
      straightMask[i] = (i >= nextLoad_i) && (i < ldqTail_i);
      // top part from nextLoad, bottom part below the tail
      wrapMask[i]     = (i >= nextLoad_i) || (i < ldqTail_i);
    end
  end

  always_comb
  begin
    if (ldqAllYounger)
      windowMask_o = '1;
    else if (ldqWrap)
      windowMask_o = wrapMask;
    else
      windowMask_o = straightMask;
  end

endmodule

// File: src/storeViolationCheck.sv
`timescale 1ns/1ps

module storeViolationCheck #(
  parameter int lsqDepth = 8
) (
  input  logic                            stValid_i,
  input  stxPkg::ldstSize_e               stSize_i,
  input  logic [stxPkg::ADDR_WIDTH-1:0]   stAddr_i,
  input  logic [$clog2(lsqDepth)-1:0]     nextLoad_i,
  input  logic [lsqDepth-1:0]             windowMask_i,
  ldqView_if.reader                       view,
  output logic                            vioValid_o,
  output logic [stxPkg::AL_ID_WIDTH-1:0]  vioAlId_o
);

  localparam int idxW = $clog2(lsqDepth);

  // store address, split into word and byte offset
  stxPkg::memAddr_u stAddrView;

  // slots touching the store's bytes
  logic [lsqDepth-1:0] matchVec;

  // executed, written back, younger and overlapping
  logic [lsqDepth-1:0] violateVec;

  assign stAddrView = stAddr_i;

  always_comb
  begin : byteMatch
    stxPkg::ldstSize_e maxSize;
    for (int i = 0; i < lsqDepth; i++)
    begin
      // larger of the two sizes decides how many offset bits count
      maxSize = (stSize_i > view.size[i]) ? stSize_i : view.size[i];
      matchVec[i] = (stAddrView.parts.wordAddr == view.addr[i].parts.wordAddr);
      case (maxSize)
        stxPkg::SIZE_BYTE:
        begin
          matchVec[i] = matchVec[i] &&
                        (stAddrView.parts.byteOff == view.addr[i].parts.byteOff);
        end
        stxPkg::SIZE_HALF:
        begin
          matchVec[i] = matchVec[i] &&
                        (stAddrView.parts.byteOff[1] == view.addr[i].parts.byteOff[1]);
        end
        // whole word, offset ignored
        default:
        begin
          matchVec[i] = matchVec[i];
        end
      endcase
    end
  end

  assign violateVec = view.addrValid & view.writeBack & windowMask_i & matchVec;

  always_comb
  begin : firstViolator
    int unsigned     idx;
    logic            found;
    logic [idxW-1:0] firstIdx;
    found    = 1'b0;
    firstIdx = '0;
    // circular scan, oldest younger load first
    for (int i = 0; i < lsqDepth; i++)
    begin
      idx = nextLoad_i + i;
      // explicit wrap, depth need not be a power of two
      if (idx >= lsqDepth)
        idx = idx - lsqDepth;
      if (violateVec[idx] && !found)
      begin
        found    = 1'b1;
        firstIdx = idx[idxW-1:0];
      end
    end
    vioValid_o = stValid_i && found;
    vioAlId_o  = vioValid_o ? view.alId[firstIdx] : '0;
  end

endmodule

// File: src/replaySelect.sv
`timescale 1ns/1ps

module replaySelect #(
  parameter int lsqDepth = 8
) (
  input  logic [$clog2(lsqDepth)-1:0]      ldqHead_i,
  ldqView_if.reader                        view,
  output logic                             replayValid_o,
  output logic [$clog2(lsqDepth)-1:0]      replayLsqId_o,
  output logic [stxPkg::PHY_TAG_WIDTH-1:0] replayPhyDest_o,
  output logic [stxPkg::AL_ID_WIDTH-1:0]   replayAlId_o,
  output stxPkg::ldstSize_e                replaySize_o,
  output logic [stxPkg::ADDR_WIDTH-1:0]    replayAddr_o
);

  // head load stalled with an address but no data yet
  logic headStalled;

  assign headStalled = view.addrValid[ldqHead_i] && !view.writeBack[ldqHead_i];

  // packet always built from the head slot
  always_comb
  begin
    replayValid_o   = headStalled;
    replayLsqId_o   = ldqHead_i;
    replayPhyDest_o = view.phyDest[ldqHead_i];
    replayAlId_o    = view.alId[ldqHead_i];
    replaySize_o    = view.size[ldqHead_i];
    // flat view, the replayed load goes back through address match
    replayAddr_o    = view.addr[ldqHead_i].flat;
  end

endmodule

// File: src/stxPath.sv
`timescale 1ns/1ps

module stxPath #(
  parameter int lsqDepth      = 8,
  parameter int dispatchWidth = 2,
  parameter int commitWidth   = 2
) (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              recover_i,
  input  logic                              backEndReady_i,
  // executing load
  input  logic                              ldValid_i,
  input  logic [$clog2(lsqDepth)-1:0]       ldLsqId_i,
  input  logic [stxPkg::PHY_TAG_WIDTH-1:0]  ldPhyDest_i,
  input  logic [stxPkg::AL_ID_WIDTH-1:0]    ldAlId_i,
  input  stxPkg::ldstSize_e                 ldSize_i,
  input  logic [stxPkg::ADDR_WIDTH-1:0]     ldAddr_i,
  input  logic                              loadDataValid_i,
  // executing store
  input  logic                              stValid_i,
  input  logic [$clog2(lsqDepth)-1:0]       stLsqId_i,
  input  stxPkg::ldstSize_e                 stSize_i,
  input  logic [stxPkg::ADDR_WIDTH-1:0]     stAddr_i,
  // dispatch lanes
  input  logic [dispatchWidth-1:0]          dispIsLoad_i,
  input  logic [dispatchWidth-1:0]          dispIsStore_i,
  input  logic [$clog2(lsqDepth)-1:0]       dispLdqId_i [dispatchWidth],
  input  logic [$clog2(lsqDepth)-1:0]       dispStqId_i [dispatchWidth],
  input  logic [$clog2(lsqDepth)-1:0]       dispNextLd_i [dispatchWidth],
  // commit lanes
  input  logic [$clog2(commitWidth):0]      commitLdCount_i,
  input  logic [$clog2(lsqDepth)-1:0]       commitLdIndex_i [commitWidth],
  // load queue pointers
  input  logic [$clog2(lsqDepth)-1:0]       ldqHead_i,
  input  logic [$clog2(lsqDepth)-1:0]       ldqTail_i,
  input  logic [$clog2(lsqDepth):0]         ldqCount_i,
  // replay packet
  output logic                              replayValid_o,
  output logic [$clog2(lsqDepth)-1:0]       replayLsqId_o,
  output logic [stxPkg::PHY_TAG_WIDTH-1:0]  replayPhyDest_o,
  output logic [stxPkg::AL_ID_WIDTH-1:0]    replayAlId_o,
  output stxPkg::ldstSize_e                 replaySize_o,
  output logic [stxPkg::ADDR_WIDTH-1:0]     replayAddr_o,
  // ordering violation
  output logic                              vioValid_o,
  output logic [stxPkg::AL_ID_WIDTH-1:0]    vioAlId_o
);

  // first younger load of the executing store
  logic [$clog2(lsqDepth)-1:0] nextLoad;

  // slots younger than that store
  logic [lsqDepth-1:0] windowMask;

  ldqView_if #(.lsqDepth(lsqDepth)) ldqView ();

  loadQueuePayload #(
    .lsqDepth      (lsqDepth),
    .dispatchWidth (dispatchWidth),
    .commitWidth   (commitWidth)
  ) uPayload (
    .clk             (clk),
    .reset           (reset),
    .recover_i       (recover_i),
    .backEndReady_i  (backEndReady_i),
    .ldValid_i       (ldValid_i),
    .ldLsqId_i       (ldLsqId_i),
    .ldPhyDest_i     (ldPhyDest_i),
    .ldAlId_i        (ldAlId_i),
    .ldSize_i        (ldSize_i),
    .ldAddr_i        (ldAddr_i),
    .loadDataValid_i (loadDataValid_i),
    .dispIsLoad_i    (dispIsLoad_i),
    .dispLdqId_i     (dispLdqId_i),
    .commitLdCount_i (commitLdCount_i),
    .commitLdIndex_i (commitLdIndex_i),
    .view            (ldqView.owner)
  );

  followingLoadTable #(
    .lsqDepth      (lsqDepth),
    .dispatchWidth (dispatchWidth)
  ) uFollowingLd (
    .clk            (clk),
    .reset          (reset),
    .recover_i      (recover_i),
    .backEndReady_i (backEndReady_i),
    .dispIsStore_i  (dispIsStore_i),
    .dispStqId_i    (dispStqId_i),
    .dispNextLd_i   (dispNextLd_i),
    .stLsqId_i      (stLsqId_i),
    .nextLoad_o     (nextLoad)
  );

  loadAgeWindow #(.lsqDepth(lsqDepth)) uAgeWindow (
    .nextLoad_i   (nextLoad),
    .ldqHead_i    (ldqHead_i),
    .ldqTail_i    (ldqTail_i),
    .ldqCount_i   (ldqCount_i),
    .windowMask_o (windowMask)
  );

  storeViolationCheck #(.lsqDepth(lsqDepth)) uVioCheck (
    .stValid_i    (stValid_i),
    .stSize_i     (stSize_i),
    .stAddr_i     (stAddr_i),
    .nextLoad_i   (nextLoad),
    .windowMask_i (windowMask),
    .view         (ldqView.reader),
    .vioValid_o   (vioValid_o),
    .vioAlId_o    (vioAlId_o)
  );

  replaySelect #(.lsqDepth(lsqDepth)) uReplay (
    .ldqHead_i       (ldqHead_i),
    .view            (ldqView.reader),
    .replayValid_o   (replayValid_o),
    .replayLsqId_o   (replayLsqId_o),
    .replayPhyDest_o (replayPhyDest_o),
    .replayAlId_o    (replayAlId_o),
    .replaySize_o    (replaySize_o),
    .replayAddr_o    (replayAddr_o)
  );

endmodule

// File: tb/stxScoreboard.sv
`timescale 1ns/1ps

module stxScoreboard #(
  parameter int lsqDepth      = 8,
  parameter int dispatchWidth = 2,
  parameter int commitWidth   = 2
) (
  input  logic                             clk, reset, recover_i, backEndReady_i,
  input  logic                             ldValid_i, loadDataValid_i, stValid_i,
  input  logic [$clog2(lsqDepth)-1:0]      ldLsqId_i, stLsqId_i, ldqHead_i, ldqTail_i,
  input  logic [$clog2(lsqDepth):0]        ldqCount_i,
  input  logic [stxPkg::PHY_TAG_WIDTH-1:0] ldPhyDest_i,
  input  logic [stxPkg::AL_ID_WIDTH-1:0]   ldAlId_i,
  input  stxPkg::ldstSize_e                ldSize_i, stSize_i,
  input  logic [stxPkg::ADDR_WIDTH-1:0]    ldAddr_i, stAddr_i,
  input  logic [dispatchWidth-1:0]         dispIsLoad_i, dispIsStore_i,
  input  logic [$clog2(lsqDepth)-1:0]      dispLdqId_i [dispatchWidth],
  input  logic [$clog2(lsqDepth)-1:0]      dispStqId_i [dispatchWidth],
  input  logic [$clog2(lsqDepth)-1:0]      dispNextLd_i [dispatchWidth],
  input  logic [$clog2(commitWidth):0]     commitLdCount_i,
  input  logic [$clog2(lsqDepth)-1:0]      commitLdIndex_i [commitWidth],
  // DUT outputs under check
  input  logic                             replayValid_i, vioValid_i,
  input  logic [$clog2(lsqDepth)-1:0]      replayLsqId_i,
  input  logic [stxPkg::PHY_TAG_WIDTH-1:0] replayPhyDest_i,
  input  logic [stxPkg::AL_ID_WIDTH-1:0]   replayAlId_i, vioAlId_i,
  input  stxPkg::ldstSize_e                replaySize_i,
  input  logic [stxPkg::ADDR_WIDTH-1:0]    replayAddr_i,
  output int                               replayErrs_o, vioErrs_o
);

  localparam int idxW = $clog2(lsqDepth);
  localparam int pktW = idxW + stxPkg::PHY_TAG_WIDTH + stxPkg::AL_ID_WIDTH + 2 +
                        stxPkg::ADDR_WIDTH;

  // queue model
  logic [lsqDepth-1:0]              mValid;
  logic [lsqDepth-1:0]              mWb;
  logic [stxPkg::AL_ID_WIDTH-1:0]   mAlId [lsqDepth];
  logic [stxPkg::PHY_TAG_WIDTH-1:0] mPhyDest [lsqDepth];
  stxPkg::ldstSize_e                mSize [lsqDepth];
  logic [stxPkg::ADDR_WIDTH-1:0]    mAddr [lsqDepth];
  // first younger load, per store slot
  logic [idxW-1:0]                  mNextLd [lsqDepth];

  logic                           expReplayValid;
  logic                           expVioValid;
  logic [stxPkg::AL_ID_WIDTH-1:0] expVioAlId;
  // replay packet flattened as slot, tag, alId, size, address
  logic [pktW-1:0]                expPkt;
  logic [pktW-1:0]                dutPkt;

  int replayErrs = 0;
  int vioErrs = 0;

  // bytes of the word an access touches
  function automatic logic [3:0] byteLanes(input stxPkg::ldstSize_e sz, input logic [1:0] off);
    case (sz)
      stxPkg::SIZE_BYTE: byteLanes = 4'b0001 << off;
      stxPkg::SIZE_HALF: byteLanes = 4'b0011 << {off[1], 1'b0};
      default:           byteLanes = 4'b1111;
    endcase
  endfunction

  always @(posedge clk or posedge reset)
  begin
    if (reset || recover_i)
    begin
      mValid <= '0;
      mWb    <= '0;
      for (int i = 0; i < lsqDepth; i++)
        mNextLd[i] <= '0;
    end
    else
    begin
      if (ldValid_i)
      begin
        mValid[ldLsqId_i]   <= 1'b1;
        mWb[ldLsqId_i]      <= loadDataValid_i;
        mAlId[ldLsqId_i]    <= ldAlId_i;
        mPhyDest[ldLsqId_i] <= ldPhyDest_i;
        mSize[ldLsqId_i]    <= ldSize_i;
        mAddr[ldLsqId_i]    <= ldAddr_i;
      end
      // clears come after the write, so they win on the same slot
      if (backEndReady_i)
      begin
        for (int d = 0; d < dispatchWidth; d++)
        begin
          if (dispIsLoad_i[d])
          begin
            mValid[dispLdqId_i[d]] <= 1'b0;
            mWb[dispLdqId_i[d]]    <= 1'b0;
          end
          if (dispIsStore_i[d])
            mNextLd[dispStqId_i[d]] <= dispNextLd_i[d];
        end
        for (int c = 0; c < commitWidth; c++)
        begin
          if (c < commitLdCount_i)
          begin
            mValid[commitLdIndex_i[c]] <= 1'b0;
            mWb[commitLdIndex_i[c]]    <= 1'b0;
          end
        end
      end
    end
  end

  // head load waiting for data
  assign expReplayValid = mValid[ldqHead_i] && !mWb[ldqHead_i];
  assign expPkt = {ldqHead_i, mPhyDest[ldqHead_i], mAlId[ldqHead_i], mSize[ldqHead_i],
                   mAddr[ldqHead_i]};
  assign dutPkt = {replayLsqId_i, replayPhyDest_i, replayAlId_i, replaySize_i, replayAddr_i};

  // walk the younger loads oldest first, stop at the first overlap
  always_comb
  begin : expViolation
    int unsigned     span;
    int unsigned     idx;
    logic            found;
    logic [idxW-1:0] nl;
    nl = mNextLd[stLsqId_i];
    found = 1'b0;
    expVioAlId = '0;
    if (ldqTail_i == nl && ldqHead_i == nl && ldqCount_i != 0)
      span = lsqDepth;
    else
      span = (ldqTail_i + lsqDepth - nl) % lsqDepth;
    for (int k = 0; k < lsqDepth; k++)
    begin
      idx = (nl + k) % lsqDepth;
      if (k < span && !found && mValid[idx] && mWb[idx] &&
          mAddr[idx][31:2] == stAddr_i[31:2] &&
          (byteLanes(mSize[idx], mAddr[idx][1:0]) & byteLanes(stSize_i, stAddr_i[1:0])) != 0)
      begin
        found = 1'b1;
        expVioAlId = mAlId[idx];
      end
    end
    expVioValid = stValid_i && found;
  end

  replayValidChk: assert property (@(posedge clk) disable iff (reset)
    replayValid_i == expReplayValid)
  else
  begin
    replayErrs++;
    $display("error %0t: replayValid_o is %b, expected %b", $time,
             $sampled(replayValid_i), $sampled(expReplayValid));
  end

  replayPktChk: assert property (@(posedge clk) disable iff (reset)
    expReplayValid |-> dutPkt == expPkt)
  else
  begin
    replayErrs++;
    $display("error %0t: replay packet %h, expected %h", $time, $sampled(dutPkt),
             $sampled(expPkt));
  end

  vioValidChk: assert property (@(posedge clk) disable iff (reset)
    vioValid_i == expVioValid)
  else
  begin
    vioErrs++;
    $display("error %0t: vioValid_o is %b, expected %b", $time, $sampled(vioValid_i),
             $sampled(expVioValid));
  end

  vioAlIdChk: assert property (@(posedge clk) disable iff (reset)
    expVioValid |-> vioAlId_i == expVioAlId)
  else
  begin
    vioErrs++;
    $display("error %0t: vioAlId_o is %h, expected %h", $time, $sampled(vioAlId_i),
             $sampled(expVioAlId));
  end

  assign replayErrs_o = replayErrs;
  assign vioErrs_o    = vioErrs;

endmodule

// File: tb/stxPathTb.sv
`timescale 1ns/1ps

module stxPathTb;

  localparam int lsqDepth      = 8;
  localparam int dispatchWidth = 2;
  localparam int commitWidth   = 2;
  localparam int idxW          = $clog2(lsqDepth);
  localparam int alW           = stxPkg::AL_ID_WIDTH;
  localparam int tagW          = stxPkg::PHY_TAG_WIDTH;
  // six tests of about 200 cycles plus margin
  localparam int timeoutCycles = 6 * 200 + 300;

  logic                         clk, reset, recover_i, backEndReady_i;
  logic                         ldValid_i, loadDataValid_i, stValid_i;
  logic [idxW-1:0]              ldLsqId_i, stLsqId_i, ldqHead_i, ldqTail_i;
  logic [idxW:0]                ldqCount_i;
  logic [tagW-1:0]              ldPhyDest_i;
  logic [alW-1:0]               ldAlId_i;
  stxPkg::ldstSize_e            ldSize_i, stSize_i;
  logic [stxPkg::ADDR_WIDTH-1:0] ldAddr_i, stAddr_i;
  logic [dispatchWidth-1:0]     dispIsLoad_i, dispIsStore_i;
  logic [idxW-1:0]              dispLdqId_i [dispatchWidth];
  logic [idxW-1:0]              dispStqId_i [dispatchWidth];
  logic [idxW-1:0]              dispNextLd_i [dispatchWidth];
  logic [$clog2(commitWidth):0] commitLdCount_i;
  logic [idxW-1:0]              commitLdIndex_i [commitWidth];

  // DUT outputs
  logic                          replayValid_o, vioValid_o;
  logic [idxW-1:0]               replayLsqId_o;
  logic [tagW-1:0]               replayPhyDest_o;
  logic [alW-1:0]                replayAlId_o, vioAlId_o;
  stxPkg::ldstSize_e             replaySize_o;
  logic [stxPkg::ADDR_WIDTH-1:0] replayAddr_o;

  logic [15:0] lfsrState = 16'd91;
  int          cycleCount = 0;
  int          replayErrs;
  int          vioErrs;

  stxPath #(
    .lsqDepth      (lsqDepth),
    .dispatchWidth (dispatchWidth),
    .commitWidth   (commitWidth)
  ) u_dut (.*);

  stxScoreboard #(
    .lsqDepth      (lsqDepth),
    .dispatchWidth (dispatchWidth),
    .commitWidth   (commitWidth)
  ) u_sb (
    .*,
    .replayValid_i   (replayValid_o),
    .vioValid_i      (vioValid_o),
    .replayLsqId_i   (replayLsqId_o),
    .replayPhyDest_i (replayPhyDest_o),
    .replayAlId_i    (replayAlId_o),
    .vioAlId_i       (vioAlId_o),
    .replaySize_i    (replaySize_o),
    .replayAddr_i    (replayAddr_o),
    .replayErrs_o    (replayErrs),
    .vioErrs_o       (vioErrs)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount == timeoutCycles)
    begin
      $display("timeout: the run did not finish within %0d cycles", timeoutCycles);
      $display("Something failed");
      $finish;
    end
  end

  // 16-bit Galois LFSR stepped once per bit
  function automatic logic lfsrStep();
    logic outBit;
    outBit = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (outBit)
      lfsrState = lfsrState ^ 16'hB400;
    return outBit;
  endfunction

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++)
      v = {v[30:0], lfsrStep()};
    return v;
  endfunction

  function automatic stxPkg::ldstSize_e randSize();
    logic [1:0] code;
    code = 2'(randBits(2));
    // unused code folds onto word
    if (code == 2'd3)
      code = 2'd2;
    return stxPkg::ldstSize_e'(code);
  endfunction

  // all tasks start and end on a falling edge
  task automatic execLoad(input logic [idxW-1:0] slot, input stxPkg::ldstSize_e sz,
                          input logic [31:0] addr, input logic withData);
    ldValid_i       = 1'b1;
    ldLsqId_i       = slot;
    ldSize_i        = sz;
    ldAddr_i        = addr;
    loadDataValid_i = withData;
    // slot in the low bits keeps alIds apart
    ldAlId_i        = alW'({randBits(alW - idxW), slot});
    ldPhyDest_i     = tagW'(randBits(tagW));
    @(negedge clk);
    ldValid_i = 1'b0;
  endtask

  task automatic execStore(input logic [idxW-1:0] slot, input stxPkg::ldstSize_e sz,
                           input logic [31:0] addr);
    stValid_i = 1'b1;
    stLsqId_i = slot;
    stSize_i  = sz;
    stAddr_i  = addr;
    @(negedge clk);
    stValid_i = 1'b0;
  endtask

  // store on lane 0 and load on lane 1
  task automatic dispatch(input logic isLd, input logic [idxW-1:0] ldSlot, input logic isSt,
                          input logic [idxW-1:0] stSlot, input logic [idxW-1:0] nextLd);
    dispIsStore_i   = {1'b0, isSt};
    dispIsLoad_i    = {isLd, 1'b0};
    dispStqId_i[0]  = stSlot;
    dispNextLd_i[0] = nextLd;
    dispLdqId_i[1]  = ldSlot;
    @(negedge clk);
    dispIsStore_i = '0;
    dispIsLoad_i  = '0;
  endtask

  task automatic commitLoads(input int count, input logic [idxW-1:0] a,
                             input logic [idxW-1:0] b);
    commitLdCount_i    = ($clog2(commitWidth) + 1)'(count);
    commitLdIndex_i[0] = a;
    commitLdIndex_i[1] = b;
    @(negedge clk);
    commitLdCount_i = '0;
  endtask

  task automatic setPointers(input logic [idxW-1:0] head, input logic [idxW-1:0] tail,
                             input logic [idxW:0] count);
    ldqHead_i  = head;
    ldqTail_i  = tail;
    ldqCount_i = count;
  endtask

  initial
  begin : mainSeq
    logic [31:0] base;
    logic [1:0]  offA;
    logic [1:0]  offB;
    reset = 1'b1;
    recover_i = 1'b0;
    backEndReady_i = 1'b1;
    ldValid_i = 1'b0;
    loadDataValid_i = 1'b0;
    stValid_i = 1'b0;
    ldLsqId_i = '0;
    stLsqId_i = '0;
    ldPhyDest_i = '0;
    ldAlId_i = '0;
    ldSize_i = stxPkg::SIZE_BYTE;
    stSize_i = stxPkg::SIZE_BYTE;
    ldAddr_i = '0;
    stAddr_i = '0;
    dispIsLoad_i = '0;
    dispIsStore_i = '0;
    dispLdqId_i = '{default: '0};
    dispStqId_i = '{default: '0};
    dispNextLd_i = '{default: '0};
    commitLdCount_i = '0;
    commitLdIndex_i = '{default: '0};
    setPointers(0, 0, 0);
    repeat (8) @(negedge clk);
    reset = 1'b0;

    // quiet after reset so a store finds nothing
    repeat (3) @(negedge clk);
    execStore(0, stxPkg::SIZE_WORD, randBits(32));

    // replay of the head load until its data arrives
    setPointers(2, 6, 4);
    base = randBits(32);
    execLoad(2, stxPkg::SIZE_WORD, base, 1'b0);
    execLoad(3, stxPkg::SIZE_BYTE, base, 1'b0);
    repeat (2) @(negedge clk);
    execLoad(2, stxPkg::SIZE_HALF, base, 1'b1);

    // straight window 2..5 around older and beyond-tail loads
    setPointers(0, 6, 6);
    dispatch(1'b0, 0, 1'b1, 3, 2);
    base = randBits(30) << 2;
    for (int s = 0; s < lsqDepth; s++)
      execLoad(s, stxPkg::SIZE_WORD, base, 1'b1);
    execStore(3, stxPkg::SIZE_WORD, base);
    commitLoads(1, 2, 0);
    execStore(3, stxPkg::SIZE_BYTE, base + 1);
    // only the committed slot 2 lies before the tail
    setPointers(0, 3, 3);
    execStore(3, stxPkg::SIZE_WORD, base);
    // wrapped window 6,7,0,1,2
    setPointers(5, 3, 6);
    dispatch(1'b0, 0, 1'b1, 1, 6);
    execStore(1, stxPkg::SIZE_HALF, base + 2);
    // full queue and then empty queue with equal pointers
    setPointers(4, 4, 8);
    dispatch(1'b0, 0, 1'b1, 2, 4);
    execStore(2, stxPkg::SIZE_WORD, base);
    setPointers(4, 4, 0);
    execStore(2, stxPkg::SIZE_WORD, base);

    // offset and size combinations
    setPointers(0, 4, 4);
    dispatch(1'b0, 0, 1'b1, 0, 1);
    for (int i = 0; i < 30; i++)
    begin
      base = randBits(30) << 2;
      offA = 2'(randBits(2));
      case (i % 3)
        0:
        begin
          execLoad(1, stxPkg::SIZE_BYTE, base | offA, 1'b1);
          offB = offA + 2'(1 + randBits(2) % 3);
          execStore(0, stxPkg::SIZE_BYTE, base | offB);
        end
        1:
        begin
          execLoad(1, randSize(), base | offA, 1'b1);
          execStore(0, stxPkg::SIZE_WORD, base | randBits(2));
        end
        default:
        begin
          execLoad(1, randSize(), base | offA, 1'b1);
          execStore(0, randSize(), (base + 4) | offA);
        end
      endcase
    end

    // clears are ignored while the back end is not ready
    setPointers(0, 6, 6);
    dispatch(1'b0, 0, 1'b1, 3, 1);
    base = randBits(30) << 2;
    execLoad(1, stxPkg::SIZE_WORD, base, 1'b1);
    execLoad(2, stxPkg::SIZE_WORD, base, 1'b1);
    execLoad(4, stxPkg::SIZE_WORD, base, 1'b1);
    execStore(3, stxPkg::SIZE_HALF, base);
    backEndReady_i = 1'b0;
    dispatch(1'b1, 1, 1'b0, 0, 0);
    commitLoads(2, 1, 2);
    execStore(3, stxPkg::SIZE_HALF, base);
    backEndReady_i = 1'b1;
    dispatch(1'b1, 1, 1'b0, 0, 0);
    execStore(3, stxPkg::SIZE_HALF, base);
    // lane 1 is beyond the count so slot 4 stays
    commitLoads(1, 2, 4);
    execStore(3, stxPkg::SIZE_HALF, base);
    setPointers(5, 6, 1);
    execLoad(5, stxPkg::SIZE_BYTE, base, 1'b0);
    backEndReady_i = 1'b0;
    commitLoads(1, 5, 0);
    backEndReady_i = 1'b1;
    commitLoads(1, 5, 0);

    // recovery wipes loads and the following-load table
    setPointers(0, 6, 6);
    execLoad(0, stxPkg::SIZE_WORD, base, 1'b0);
    execLoad(2, stxPkg::SIZE_WORD, base, 1'b1);
    recover_i = 1'b1;
    @(negedge clk);
    recover_i = 1'b0;
    execStore(3, stxPkg::SIZE_WORD, base);
    execLoad(2, stxPkg::SIZE_WORD, base, 1'b1);
    execStore(3, stxPkg::SIZE_WORD, base);

    repeat (2) @(negedge clk);
    $display("replay errors %0d, violation errors %0d", replayErrs, vioErrs);
    if (replayErrs == 0 && vioErrs == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

// File: flist.f
src/stxPkg.sv
src/ldqView_if.sv
src/loadQueuePayload.sv
src/followingLoadTable.sv
src/loadAgeWindow.sv
src/storeViolationCheck.sv
src/replaySelect.sv
src/stxPath.sv
tb/stxScoreboard.sv
tb/stxPathTb.sv
